//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_curve_plotter
FILELIST = build.f
PASS_MSG = all tests passed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- build.f
plot_pkg.sv
fixed_point_alu.sv
rpn_queue.sv
stack_machine.sv
curve_plotter_top.sv
curve_plotter_asserts.sv
tb_curve_plotter.sv

//--- curve_plotter_asserts.sv
`timescale 1ns/1ps

module curve_plotter_asserts #(
    parameter int QUEUE_SIZE = 64
) (
    input logic                            clk,
    input logic                            rst,
    input logic                            get,
    input logic                            rd_ready,
    input logic [$clog2(QUEUE_SIZE+1)-1:0] length,
    input logic                            start,
    input logic                            done
);

    // an ALU operation is in flight
    logic busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    a_get_ready: assert property (@(posedge clk) disable iff (rst) get |=> rd_ready)
        else $error("rd_ready missing one cycle after get");

    a_ready_get: assert property (@(posedge clk) disable iff (rst) rd_ready |-> $past(get))
        else $error("rd_ready without get in the previous cycle");

    a_done_start: assert property (@(posedge clk) disable iff (rst) done |-> busy)
        else $error("ALU done without an earlier start");

    a_length: assert property (@(posedge clk) disable iff (rst) length <= QUEUE_SIZE)
        else $error("queue length above QUEUE_SIZE");

endmodule

bind rpn_queue curve_plotter_asserts #(
    .QUEUE_SIZE (QUEUE_SIZE)
) i_queue_asserts (
    .clk      (clk),
    .rst      (rst),
    .get      (get),
    .rd_ready (rd_ready),
    .length   (length),
    .start    (1'b0),
    .done     (1'b0)
);

bind fixed_point_alu curve_plotter_asserts i_alu_asserts (
    .clk      (clk),
    .rst      (rst),
    .get      (1'b0),
    .rd_ready (1'b0),
    .length   ('0),
    .start    (start),
    .done     (done)
);

//--- curve_plotter_top.sv
`timescale 1ns/1ps

module curve_plotter_top
    import plot_pkg::*;
#(
    parameter int QUEUE_SIZE = 64,
    parameter int HOR_PIXELS = 640,
    parameter int VER_PIXELS = 480
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          clear,
    input  logic                          wr_en,
    input  token_t                        wr_token,
    input  logic                          start,
    input  logic [$clog2(HOR_PIXELS)-1:0] x_pos,
    output logic                          ready,
    output logic [$clog2(VER_PIXELS)-1:0] y_pos
);

    // queue read port
    logic [$clog2(QUEUE_SIZE)-1:0]   index;
    logic                            get;
    logic [$clog2(QUEUE_SIZE+1)-1:0] length;
    token_t                          rd_token;
    logic                            rd_ready;

    rpn_queue #(
        .QUEUE_SIZE (QUEUE_SIZE)
    ) i_queue (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear),
        .wr_en    (wr_en),
        .wr_token (wr_token),
        .index    (index),
        .get      (get),
        .rd_token (rd_token),
        .rd_ready (rd_ready),
        .length   (length)
    );

    stack_machine #(
        .QUEUE_SIZE (QUEUE_SIZE),
        .HOR_PIXELS (HOR_PIXELS),
        .VER_PIXELS (VER_PIXELS)
    ) i_machine (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .x_pos    (x_pos),
        .ready    (ready),
        .y_pos    (y_pos),
        .index    (index),
        .get      (get),
        .length   (length),
        .rd_token (rd_token),
        .rd_ready (rd_ready)
    );

endmodule

//--- fixed_point_alu.sv
`timescale 1ns/1ps

module fixed_point_alu
    import plot_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  op_code_t op,
    input  number_t  a,
    input  number_t  b,
    output logic     done,
    output number_t  result
);

    localparam int DIV_STEPS = NUM_W + FRAC_W;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);
    // counter also holds a power exponent up to 127
    localparam int CNT_W = (INT_W > DIV_CNT_W) ? INT_W : DIV_CNT_W;

    localparam number_t ONE     = number_t'(1 << FRAC_W);
    localparam number_t MAX_POS = {1'b0, {(NUM_W-1){1'b1}}};

    typedef enum logic [1:0] {
        S_IDLE,
        S_DIV,
        S_POW
    } alu_state_t;

    alu_state_t state;
    logic [CNT_W-1:0] step_cnt;

    // divider registers
    logic [DIV_STEPS-1:0] div_quo;
    logic [NUM_W:0]       div_rem;
    logic [NUM_W-1:0]     div_dvs;
    logic                 div_neg;
    logic                 div_zero;

    logic [NUM_W:0]       rem_shift;
    logic [NUM_W+1:0]     rem_diff;
    logic [NUM_W:0]       rem_next;
    logic [DIV_STEPS-1:0] quo_next;
    number_t              quo_mag;

    // power state
    number_t                  pow_base;
    logic signed [INT_W-1:0]  b_int;

    function automatic number_t fx_mul(number_t x, number_t y);
        product_t prod;
        prod = x * y;
        return number_t'(prod >>> FRAC_W);
    endfunction

    function automatic logic [NUM_W-1:0] magnitude(number_t v);
        return v[NUM_W-1] ? NUM_W'(-v) : NUM_W'(v);
    endfunction

    assign b_int = b[NUM_W-1:FRAC_W];

    // one restoring step per cycle
    always_comb begin
        rem_shift = {div_rem[NUM_W-1:0], div_quo[DIV_STEPS-1]};
        rem_diff  = {1'b0, rem_shift} - {2'b00, div_dvs};
        if (rem_diff[NUM_W+1]) begin
            rem_next = rem_shift;
            quo_next = {div_quo[DIV_STEPS-2:0], 1'b0};
        end else begin
            rem_next = rem_diff[NUM_W:0];
            quo_next = {div_quo[DIV_STEPS-2:0], 1'b1};
        end
        quo_mag = number_t'(quo_next[NUM_W-1:0]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        case (op)
                            OP_ADD: begin
                                result <= a + b;
                                done   <= 1'b1;
                            end
                            OP_SUB: begin
                                result <= a - b;
                                done   <= 1'b1;
                            end
                            OP_MUL: begin
                                result <= fx_mul(a, b);
                                done   <= 1'b1;
                            end
                            OP_DIV: begin
                                div_quo  <= {magnitude(a), FRAC_W'(0)};
                                div_rem  <= '0;
                                div_dvs  <= magnitude(b);
                                div_neg  <= a[NUM_W-1] ^ b[NUM_W-1];
                                div_zero <= (b == '0);
                                step_cnt <= CNT_W'(DIV_STEPS);
                                state    <= S_DIV;
                            end
                            OP_POW: begin
                                result <= ONE;
                                // negative or zero exponent gives one
                                if (b_int <= 0) begin
                                    done <= 1'b1;
                                end else begin
                                    pow_base <= a;
                                    step_cnt <= CNT_W'($unsigned(b_int));
                                    state    <= S_POW;
                                end
                            end
                            default: begin
                                result <= '0;
                                done   <= 1'b1;
                            end
                        endcase
                    end
                end
                S_DIV: begin
                    div_quo  <= quo_next;
                    div_rem  <= rem_next;
                    step_cnt <= step_cnt - 1'b1;
                    if (step_cnt == CNT_W'(1)) begin
                        if (div_zero) begin
                            result <= MAX_POS;
                        end else begin
                            result <= div_neg ? -quo_mag : quo_mag;
                        end
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                S_POW: begin
                    // result doubles as the accumulator
                    result   <= fx_mul(result, pow_base);
                    step_cnt <= step_cnt - 1'b1;
                    if (step_cnt == CNT_W'(1)) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- plot_pkg.sv
package plot_pkg;

    // Q8.8 signed number format
    localparam int INT_W  = 8;
    localparam int FRAC_W = 8;
    localparam int NUM_W  = INT_W + FRAC_W;

    // operand stack of the evaluator
    localparam int STACK_DEPTH = 64;

    typedef logic signed [NUM_W-1:0] number_t;

    // full-precision product and scaled intermediates
    typedef logic signed [2*NUM_W-1:0] product_t;

    typedef logic [2:0] op_code_t;

    localparam op_code_t OP_ADD = 3'd0;
    localparam op_code_t OP_SUB = 3'd1;
    localparam op_code_t OP_MUL = 3'd2;
    localparam op_code_t OP_DIV = 3'd3;
    localparam op_code_t OP_POW = 3'd4;
    // push the current x instead of a constant
    localparam op_code_t OP_VAR = 3'd6;

    // low bits of value carry the op code when is_op is set
    typedef struct packed {
        logic    is_op;
        number_t value;
    } token_t;

endpackage

//--- rpn_queue.sv
`timescale 1ns/1ps

module rpn_queue
    import plot_pkg::*;
#(
    parameter int QUEUE_SIZE = 64
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            clear,
    input  logic                            wr_en,
    input  token_t                          wr_token,
    input  logic [$clog2(QUEUE_SIZE)-1:0]   index,
    input  logic                            get,
    output token_t                          rd_token,
    output logic                            rd_ready,
    output logic [$clog2(QUEUE_SIZE+1)-1:0] length
);

    localparam int IDX_W = $clog2(QUEUE_SIZE);
    localparam int LEN_W = $clog2(QUEUE_SIZE + 1);

    token_t           mem [QUEUE_SIZE];
    logic [LEN_W-1:0] wr_ptr;
    logic             wr_ok;

    // full queue drops further writes
    assign wr_ok  = wr_en && !clear && (wr_ptr < LEN_W'(QUEUE_SIZE));
    assign length = wr_ptr;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr <= '0;
        end else if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr[IDX_W-1:0]] <= wr_token;
        end
    end

    // registered read, ready one cycle after get
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ready <= 1'b0;
        end else begin
            rd_ready <= get;
        end
    end

    always_ff @(posedge clk) begin
        if (get) begin
            rd_token <= mem[index];
        end
    end

endmodule

//--- stack_machine.sv
`timescale 1ns/1ps

module stack_machine
    import plot_pkg::*;
#(
    parameter int QUEUE_SIZE = 64,
    parameter int HOR_PIXELS = 640,
    parameter int VER_PIXELS = 480
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic [$clog2(HOR_PIXELS)-1:0]   x_pos,
    output logic                            ready,
    output logic [$clog2(VER_PIXELS)-1:0]   y_pos,
    output logic [$clog2(QUEUE_SIZE)-1:0]   index,
    output logic                            get,
    input  logic [$clog2(QUEUE_SIZE+1)-1:0] length,
    input  token_t                          rd_token,
    input  logic                            rd_ready
);

    localparam int IDX_W     = $clog2(QUEUE_SIZE);
    localparam int LEN_W     = $clog2(QUEUE_SIZE + 1);
    localparam int Y_W       = $clog2(VER_PIXELS);
    localparam int SP_W      = $clog2(STACK_DEPTH + 1);
    localparam int STK_IDX_W = $clog2(STACK_DEPTH);
    localparam int ROW_W     = 2*NUM_W - FRAC_W;

    // pixels per world unit
    localparam int SCALE     = 20;
    // offset column is pre-divided by 4 so it fits Q8.8, the ALU divides by 5
    localparam int PRE_SHIFT = 2;
    localparam number_t X_DIVISOR = number_t'((SCALE >> PRE_SHIFT) << FRAC_W);

    typedef enum logic [3:0] {
        S_READY,
        S_XFORM_X,
        S_FETCH,
        S_FETCH_WAIT,
        S_ANALYZE,
        S_PUSH_VAR,
        S_PUSH_VAL,
        S_OPERATE,
        S_OPERATE_WAIT,
        S_XFORM_Y,
        S_CLAMP_Y
    } sm_state_t;

    sm_state_t        state;
    number_t          x_world;
    token_t           token;
    logic [LEN_W-1:0] tok_cnt;

    // operand stack
    number_t          stack [STACK_DEPTH];
    logic [SP_W-1:0]  sp;
    logic [SP_W-1:0]  sp_m1;
    logic [SP_W-1:0]  sp_m2;
    logic             stk_full;
    logic             stk_we;
    logic [SP_W-1:0]  stk_waddr;
    number_t          stk_wdata;

    logic     alu_start;
    logic     alu_done;
    op_code_t alu_op;
    number_t  alu_a;
    number_t  alu_b;
    number_t  alu_result;

    product_t         x_off;
    number_t          x_scaled;
    number_t          bottom;
    product_t         row_fx;
    logic [ROW_W-1:0] row_int;

    fixed_point_alu i_alu (
        .clk    (clk),
        .rst    (rst),
        .start  (alu_start),
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .done   (alu_done),
        .result (alu_result)
    );

    assign ready    = (state == S_READY);
    assign index    = tok_cnt[IDX_W-1:0];
    assign sp_m1    = sp - 1'b1;
    assign sp_m2    = sp - 2'd2;
    assign stk_full = (sp == SP_W'(STACK_DEPTH));

    // column offset from screen centre, scaled into Q8.8
    assign x_off    = product_t'(x_pos) - product_t'(HOR_PIXELS / 2);
    assign x_scaled = number_t'(x_off <<< (FRAC_W - PRE_SHIFT));

    // empty stack evaluates to zero
    assign bottom   = (sp != '0) ? stack[0] : '0;
    // integer part, negative rows read as large unsigned values
    assign row_int  = row_fx[2*NUM_W-1:FRAC_W];

    always_comb begin
        stk_we    = 1'b0;
        stk_waddr = sp;
        stk_wdata = x_world;
        case (state)
            S_PUSH_VAR: begin
                stk_we = !stk_full;
            end
            S_PUSH_VAL: begin
                stk_we    = !stk_full;
                stk_wdata = token.value;
            end
            S_OPERATE_WAIT: begin
                stk_we    = alu_done;
                stk_waddr = sp_m2;
                stk_wdata = alu_result;
            end
            default: begin
                stk_we = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (stk_we) begin
            stack[stk_waddr[STK_IDX_W-1:0]] <= stk_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_READY;
            get       <= 1'b0;
            alu_start <= 1'b0;
            tok_cnt   <= '0;
            sp        <= '0;
            y_pos     <= '0;
        end else begin
            get       <= 1'b0;
            alu_start <= 1'b0;
            case (state)
                S_READY: begin
                    if (start) begin
                        tok_cnt   <= '0;
                        alu_op    <= OP_DIV;
                        alu_a     <= x_scaled;
                        alu_b     <= X_DIVISOR;
                        alu_start <= 1'b1;
                        state     <= S_XFORM_X;
                    end
                end
                S_XFORM_X: begin
                    if (alu_done) begin
                        x_world <= alu_result;
                        state   <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (length <= tok_cnt) begin
                        state <= S_XFORM_Y;
                    end else begin
                        get   <= 1'b1;
                        state <= S_FETCH_WAIT;
                    end
                end
                S_FETCH_WAIT: begin
                    if (rd_ready) begin
                        token   <= rd_token;
                        tok_cnt <= tok_cnt + 1'b1;
                        state   <= S_ANALYZE;
                    end
                end
                S_ANALYZE: begin
                    if (token.is_op && token.value[2:0] == OP_VAR) begin
                        state <= S_PUSH_VAR;
                    end else if (token.is_op) begin
                        alu_op <= token.value[2:0];
                        state  <= S_OPERATE;
                    end else begin
                        state <= S_PUSH_VAL;
                    end
                end
                S_PUSH_VAR, S_PUSH_VAL: begin
                    if (!stk_full) begin
                        sp <= sp + 1'b1;
                    end
                    state <= S_FETCH;
                end
                S_OPERATE: begin
                    // underflow ends the formula early
                    if (sp < SP_W'(2)) begin
                        state <= S_XFORM_Y;
                    end else begin
                        alu_a     <= stack[sp_m2[STK_IDX_W-1:0]];
                        alu_b     <= stack[sp_m1[STK_IDX_W-1:0]];
                        alu_start <= 1'b1;
                        state     <= S_OPERATE_WAIT;
                    end
                end
                S_OPERATE_WAIT: begin
                    if (alu_done) begin
                        sp    <= sp_m1;
                        state <= S_FETCH;
                    end
                end
                S_XFORM_Y: begin
                    row_fx <= (product_t'(VER_PIXELS / 2) <<< FRAC_W)
                              - product_t'(bottom) * SCALE;
                    state  <= S_CLAMP_Y;
                end
                S_CLAMP_Y: begin
                    if (row_int > ROW_W'(VER_PIXELS)) begin
                        y_pos <= Y_W'(VER_PIXELS);
                    end else begin
                        y_pos <= row_int[Y_W-1:0];
                    end
                    sp    <= '0;
                    state <= S_READY;
                end
                default: state <= S_READY;
            endcase
        end
    end

endmodule

//--- tb_curve_plotter.sv
`timescale 1ns/1ps

module tb_curve_plotter
    import plot_pkg::*;
();

    localparam int QUEUE_SIZE  = 64;
    localparam int HOR_PIXELS  = 640;
    localparam int VER_PIXELS  = 480;
    localparam int MAX_ROWS    = 32;
    localparam int MAX_TOKENS  = 8;
    localparam int MAX_WAIT    = 2000;
    localparam int DRIVE_DELAY = 2;

    logic                          clk;
    logic                          rst;
    logic                          clear;
    logic                          wr_en;
    token_t                        wr_token;
    logic                          start;
    logic [$clog2(HOR_PIXELS)-1:0] x_pos;
    logic                          ready;
    logic [$clog2(VER_PIXELS)-1:0] y_pos;

    // test table
    string  test_name [MAX_ROWS];
    token_t test_tok  [MAX_ROWS][MAX_TOKENS];
    int     test_len  [MAX_ROWS];
    int     test_x    [MAX_ROWS];
    int     test_exp  [MAX_ROWS];
    int     num_tests;
    logic   table_done;

    int   errors;
    int   checks;
    int   last_y;
    logic stuck;
    int   i;

    curve_plotter_top #(
        .QUEUE_SIZE (QUEUE_SIZE),
        .HOR_PIXELS (HOR_PIXELS),
        .VER_PIXELS (VER_PIXELS)
    ) i_dut (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear),
        .wr_en    (wr_en),
        .wr_token (wr_token),
        .start    (start),
        .x_pos    (x_pos),
        .ready    (ready),
        .y_pos    (y_pos)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // digits are constants and x pushes the column value
    function automatic token_t char_to_token(input byte c);
        token_t t;
        t.is_op = 1'b1;
        t.value = '0;
        case (c)
            "+": t.value[2:0] = OP_ADD;
            "-": t.value[2:0] = OP_SUB;
            "*": t.value[2:0] = OP_MUL;
            "/": t.value[2:0] = OP_DIV;
            "^": t.value[2:0] = OP_POW;
            "x": t.value[2:0] = OP_VAR;
            default: begin
                t.is_op = 1'b0;
                t.value = number_t'((int'(c) - 48) * 256);
            end
        endcase
        return t;
    endfunction

    task automatic add_test(input string formula, input int x, input int exp_row);
        int  n;
        int  k;
        byte c;
        n = 0;
        for (k = 0; k < formula.len(); k++) begin
            c = formula[k];
            if (c != " " && n < MAX_TOKENS) begin
                test_tok[num_tests][n] = char_to_token(c);
                n++;
            end
        end
        test_name[num_tests] = $sformatf("'%s' at x=%0d", formula, x);
        test_len[num_tests]  = n;
        test_x[num_tests]    = x;
        test_exp[num_tests]  = exp_row;
        num_tests++;
    endtask

    task automatic build_table();
        num_tests = 0;
        add_test("3", 100, 180);
        add_test("3", 600, 180);
        add_test("", 320, 240);
        add_test("x", 320, 240);
        add_test("x", 340, 220);
        add_test("x", 380, 180);
        add_test("x", 300, 260);
        add_test("x 2 +", 340, 180);
        add_test("x 1 -", 340, 240);
        add_test("1 x -", 380, 280);
        add_test("x x *", 360, 160);
        add_test("x x *", 300, 220);
        add_test("x 2 /", 380, 210);
        // -0.5 world
        add_test("x 2 /", 300, 250);
        // 3/7 truncates to 109/256
        add_test("x 7 /", 380, 231);
        add_test("x 2 ^", 380, 60);
        add_test("x 3 ^", 330, 237);
        // exponent -1 gives one
        add_test("2 x ^", 300, 220);
        add_test("x 3 * 4 -", 360, 200);
        add_test("1 0 /", 320, 480);
        add_test("+", 320, 240);
        add_test("5 +", 320, 140);
        // world -16 gives row 560
        add_test("x", 0, 480);
        // negative row wraps high
        add_test("x", 639, 480);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_formula(input int row);
        int n;
        @(posedge clk);
        #DRIVE_DELAY;
        clear = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        clear = 1'b0;
        n = 0;
        while (n < test_len[row]) begin
            wr_en    = 1'b1;
            wr_token = test_tok[row][n];
            @(posedge clk);
            #DRIVE_DELAY;
            n++;
        end
        wr_en    = 1'b0;
        wr_token = '0;
    endtask

    task automatic pulse_start(input int row);
        if (!ready) begin
            $display("%s: ready was low when start was raised", test_name[row]);
            errors++;
        end
        start = 1'b1;
        x_pos = test_x[row][$clog2(HOR_PIXELS)-1:0];
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
    endtask

    task automatic run_test(input int row);
        int cycles;
        load_formula(row);
        check_value({test_name[row], " y_pos hold"}, last_y, y_pos);
        pulse_start(row);
        if (ready) begin
            $display("%s: ready stayed high in the cycle after start", test_name[row]);
            errors++;
        end
        cycles = 0;
        while (!ready && cycles < MAX_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!ready) begin
            $display("%s: ready never returned within %0d cycles", test_name[row], MAX_WAIT);
            errors++;
            stuck = 1'b1;
        end else begin
            check_value(test_name[row], test_exp[row], y_pos);
            last_y = test_exp[row];
        end
    endtask

    initial begin
        rst        = 1'b1;
        clear      = 1'b0;
        wr_en      = 1'b0;
        wr_token   = '0;
        start      = 1'b0;
        x_pos      = '0;
        errors     = 0;
        checks     = 0;
        last_y     = 0;
        stuck      = 1'b0;
        table_done = 1'b0;
        build_table();
        table_done = 1'b1;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(negedge clk);
        check_value("ready after reset", 1, ready);
        check_value("y_pos after reset", 0, y_pos);
        for (i = 0; i < num_tests && !stuck; i++) begin
            run_test(i);
        end
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // run limit from the table size
    initial begin
        wait (table_done);
        repeat (num_tests * (MAX_WAIT + 20) + 50) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("tests failed");
        $finish;
    end

endmodule
